// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only -Wall --timing --assert
TOP        = tb_mycpu
FILELIST   = verilog.f
OBJ_DIR    = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// ==== rtl/cpu_pkg.sv ====
// cpu_pkg: shared widths, reset PC, MIPS opcode and function codes
// plus the ALU operation encoding for the integer pipeline
`default_nettype none

package cpu_pkg;

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    localparam logic [31:0] reset_pc = 32'hbfc00000;   // boot vector

    // major opcodes, instr[31:26]
    localparam logic [5:0] op_special = 6'b000000;
    localparam logic [5:0] op_addiu   = 6'b001001;
    localparam logic [5:0] op_slti    = 6'b001010;
    localparam logic [5:0] op_andi    = 6'b001100;
    localparam logic [5:0] op_ori     = 6'b001101;
    localparam logic [5:0] op_xori    = 6'b001110;
    localparam logic [5:0] op_lui     = 6'b001111;

    // SPECIAL function field, instr[5:0]
    localparam logic [5:0] fn_sll  = 6'b000000;
    localparam logic [5:0] fn_srl  = 6'b000010;
    localparam logic [5:0] fn_addu = 6'b100001;
    localparam logic [5:0] fn_subu = 6'b100011;
    localparam logic [5:0] fn_and  = 6'b100100;
    localparam logic [5:0] fn_or   = 6'b100101;
    localparam logic [5:0] fn_xor  = 6'b100110;
    localparam logic [5:0] fn_slt  = 6'b101010;
    localparam logic [5:0] fn_sltu = 6'b101011;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,    // signed compare
        alu_sltu,   // unsigned compare
        alu_sll,
        alu_srl,
        alu_lui
    } alu_op_t;

endpackage

`default_nettype wire

// ==== rtl/exe_stage.sv ====
// exe_stage: integer ALU and the EXE/WB register
// drives the execute bypass and the writeback trace
`timescale 1ns/1ns
`default_nettype none

module exe_stage import cpu_pkg::*; (
    input  logic         aclk,
    input  logic         rst_n,
    input  logic         ex_valid,
    input  logic [31:0]  ex_pc,
    input  alu_op_t      ex_op,
    input  logic [31:0]  ex_a,
    input  logic [31:0]  ex_b,
    input  logic [4:0]   ex_dst,
    input  logic         ex_wr,
    output logic         exe_wr,
    output logic [4:0]   exe_dst,
    output logic [31:0]  exe_result,
    output logic         wb_we,
    output logic [4:0]   wb_dst,
    output logic [31:0]  wb_data,
    output logic [31:0]  debug_wb_pc,
    output logic [3:0]   debug_wb_rf_wen
);

    logic [data_w-1:0] alu_out;

    always_comb begin
        case (ex_op)
            alu_add:  alu_out = ex_a + ex_b;       // wraps, no overflow trap
            alu_sub:  alu_out = ex_a - ex_b;
            alu_and:  alu_out = ex_a & ex_b;
            alu_or:   alu_out = ex_a | ex_b;
            alu_xor:  alu_out = ex_a ^ ex_b;
            alu_slt:  alu_out = {{(data_w-1){1'b0}}, $signed(ex_a) < $signed(ex_b)};
            alu_sltu: alu_out = {{(data_w-1){1'b0}}, ex_a < ex_b};
            alu_sll:  alu_out = ex_b << ex_a[4:0];
            alu_srl:  alu_out = ex_b >> ex_a[4:0];
            alu_lui:  alu_out = {ex_b[15:0], 16'h0000};
            default:  alu_out = '0;
        endcase
    end

    // bypass back to decode, same cycle
    assign exe_wr     = ex_valid && ex_wr;
    assign exe_dst    = ex_dst;
    assign exe_result = alu_out;

    always_ff @(posedge aclk) begin
        if (!rst_n)
            wb_we <= 1'b0;
        else
            wb_we <= exe_wr;
    end

    always_ff @(posedge aclk) begin
        if (ex_valid) begin
            debug_wb_pc <= ex_pc;
            wb_data     <= alu_out;
            wb_dst      <= ex_dst;
        end
    end

    assign debug_wb_rf_wen = {4{wb_we}};    // whole-word write only

endmodule

`default_nettype wire

// ==== rtl/id_stage.sv ====
// id_stage: PC, instruction decode and operand bypass
// feeding the ID/EXE pipeline register
`timescale 1ns/1ns
`default_nettype none

module id_stage import cpu_pkg::*; (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    output logic [4:0]            rs_addr,
    output logic [4:0]            rt_addr,
    input  logic [31:0]           rs_data,
    input  logic [31:0]           rt_data,
    input  logic                  exe_wr,
    input  logic [4:0]            exe_dst,
    input  logic [31:0]           exe_result,
    input  logic                  wb_we,
    input  logic [4:0]            wb_dst,
    input  logic [31:0]           wb_data,
    output logic                  ex_valid,
    output logic [31:0]           ex_pc,
    output alu_op_t               ex_op,
    output logic [31:0]           ex_a,
    output logic [31:0]           ex_b,
    output logic [4:0]            ex_dst,
    output logic                  ex_wr
);

    logic [data_w-1:0]     pc;
    logic [5:0]            opcode;
    logic [5:0]            funct;
    logic [reg_addr_w-1:0] rd;
    logic [reg_addr_w-1:0] sa;
    logic [15:0]           imm;
    logic [data_w-1:0]     imm_ext;
    logic [data_w-1:0]     rs_val;
    logic [data_w-1:0]     rt_val;
    logic [reg_addr_w-1:0] dst;
    alu_op_t               dec_op;
    logic                  dec_ok;      // supported encoding
    logic                  use_imm;
    logic                  use_sa;
    logic                  sign_ext;

    assign opcode  = instr[31:26];
    assign rs_addr = instr[25:21];
    assign rt_addr = instr[20:16];
    assign rd      = instr[15:11];
    assign sa      = instr[10:6];
    assign funct   = instr[5:0];
    assign imm     = instr[15:0];

    // newest producer wins: execute, then writeback, then regfile
    function automatic logic [data_w-1:0] bypass(
        input logic [reg_addr_w-1:0] src,
        input logic [data_w-1:0]     rf_val
    );
        if (src == '0)
            return '0;
        else if (exe_wr && exe_dst == src)
            return exe_result;
        else if (wb_we && wb_dst == src)
            return wb_data;
        else
            return rf_val;
    endfunction

    always_comb begin
        rs_val = bypass(rs_addr, rs_data);
        rt_val = bypass(rt_addr, rt_data);
    end

    always_comb begin
        dec_op   = alu_add;
        dec_ok   = 1'b1;
        use_imm  = 1'b1;
        use_sa   = 1'b0;
        sign_ext = 1'b0;
        case (opcode)
            op_special: begin
                use_imm = 1'b0;
                case (funct)
                    fn_sll:  begin dec_op = alu_sll; use_sa = 1'b1; end
                    fn_srl:  begin dec_op = alu_srl; use_sa = 1'b1; end
                    fn_addu: dec_op = alu_add;
                    fn_subu: dec_op = alu_sub;
                    fn_and:  dec_op = alu_and;
                    fn_or:   dec_op = alu_or;
                    fn_xor:  dec_op = alu_xor;
                    fn_slt:  dec_op = alu_slt;
                    fn_sltu: dec_op = alu_sltu;
                    default: dec_ok = 1'b0;
                endcase
            end
            op_addiu: begin dec_op = alu_add; sign_ext = 1'b1; end
            op_slti:  begin dec_op = alu_slt; sign_ext = 1'b1; end
            op_andi:  dec_op = alu_and;
            op_ori:   dec_op = alu_or;
            op_xori:  dec_op = alu_xor;
            op_lui:   dec_op = alu_lui;   // alu moves imm to upper half
            default:  dec_ok = 1'b0;
        endcase
    end

    assign imm_ext = sign_ext ? {{(data_w-16){imm[15]}}, imm} : {{(data_w-16){1'b0}}, imm};
    assign dst     = (opcode == op_special) ? rd : rt_addr;

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            ex_valid <= 1'b0;
            ex_wr    <= 1'b0;
        end else begin
            ex_valid <= instr_valid;
            ex_wr    <= dec_ok && (dst != '0);  // no write for $0 or bad encodings
            if (instr_valid)
                pc <= pc + 32'd4;
        end
    end

    // payload, qualified downstream by ex_valid
    always_ff @(posedge aclk) begin
        if (instr_valid) begin
            ex_pc  <= pc;
            ex_op  <= dec_op;
            ex_a   <= use_sa ? {{(data_w-reg_addr_w){1'b0}}, sa} : rs_val;
            ex_b   <= use_imm ? imm_ext : rt_val;
            ex_dst <= dst;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/mycpu_top.sv ====
// mycpu_top: in-order integer pipeline, decode -> execute -> writeback
// with golden-trace debug ports on the writeback stage
`timescale 1ns/1ns
`default_nettype none

module mycpu_top import cpu_pkg::*; (
    input  logic                  aclk,
    input  logic                  rst_n,
    input  logic                  instr_valid,
    input  logic [31:0]           instr,
    output logic [31:0]           debug_wb_pc,
    output logic [31:0]           debug_wb_rf_wdata,
    output logic [3:0]            debug_wb_rf_wen,
    output logic [4:0]            debug_wb_rf_wnum
);

    logic [reg_addr_w-1:0] rs_addr;
    logic [reg_addr_w-1:0] rt_addr;
    logic [data_w-1:0]     rs_data;
    logic [data_w-1:0]     rt_data;

    // ID/EXE register contents
    logic                  ex_valid;
    logic [data_w-1:0]     ex_pc;
    alu_op_t               ex_op;
    logic [data_w-1:0]     ex_a;
    logic [data_w-1:0]     ex_b;
    logic [reg_addr_w-1:0] ex_dst;
    logic                  ex_wr;

    logic                  exe_wr;      // execute bypass
    logic [reg_addr_w-1:0] exe_dst;
    logic [data_w-1:0]     exe_result;

    logic                  wb_we;       // writeback, also bypass
    logic [reg_addr_w-1:0] wb_dst;
    logic [data_w-1:0]     wb_data;

    assign debug_wb_rf_wdata = wb_data;
    assign debug_wb_rf_wnum  = wb_dst;

    id_stage u_id_stage (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs_addr     (rs_addr),
        .rt_addr     (rt_addr),
        .rs_data     (rs_data),
        .rt_data     (rt_data),
        .exe_wr      (exe_wr),
        .exe_dst     (exe_dst),
        .exe_result  (exe_result),
        .wb_we       (wb_we),
        .wb_dst      (wb_dst),
        .wb_data     (wb_data),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_op       (ex_op),
        .ex_a        (ex_a),
        .ex_b        (ex_b),
        .ex_dst      (ex_dst),
        .ex_wr       (ex_wr)
    );

    regfile u_regfile (
        .aclk    (aclk),
        .rs_addr (rs_addr),
        .rt_addr (rt_addr),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .wb_we   (wb_we),
        .wb_dst  (wb_dst),
        .wb_data (wb_data)
    );

    exe_stage u_exe_stage (
        .aclk            (aclk),
        .rst_n           (rst_n),
        .ex_valid        (ex_valid),
        .ex_pc           (ex_pc),
        .ex_op           (ex_op),
        .ex_a            (ex_a),
        .ex_b            (ex_b),
        .ex_dst          (ex_dst),
        .ex_wr           (ex_wr),
        .exe_wr          (exe_wr),
        .exe_dst         (exe_dst),
        .exe_result      (exe_result),
        .wb_we           (wb_we),
        .wb_dst          (wb_dst),
        .wb_data         (wb_data),
        .debug_wb_pc     (debug_wb_pc),
        .debug_wb_rf_wen (debug_wb_rf_wen)
    );

endmodule

`default_nettype wire

// ==== rtl/regfile.sv ====
// regfile: 32 x 32 general purpose registers
// two async read ports, one clocked write port, $0 reads as zero
`timescale 1ns/1ns
`default_nettype none

module regfile import cpu_pkg::*; (
    input  logic         aclk,
    input  logic [4:0]   rs_addr,
    input  logic [4:0]   rt_addr,
    output logic [31:0]  rs_data,
    output logic [31:0]  rt_data,
    input  logic         wb_we,
    input  logic [4:0]   wb_dst,
    input  logic [31:0]  wb_data
);

    logic [data_w-1:0] regs [2**reg_addr_w];

    always_ff @(posedge aclk) begin
        if (wb_we && wb_dst != '0)
            regs[wb_dst] <= wb_data;
    end

    // entry 0 is never written, force zero on read
    assign rs_data = (rs_addr == '0) ? '0 : regs[rs_addr];
    assign rt_data = (rt_addr == '0) ? '0 : regs[rt_addr];

endmodule

`default_nettype wire

// ==== test/clk_gen.sv ====
// clk_gen: free-running testbench clock, 100 ns period
`timescale 1ns/1ns
`default_nettype none

module clk_gen (
    output logic clk
);

    localparam int half_period = 50;

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

endmodule

`default_nettype wire

// ==== test/mycpu_assert.sv ====
// mycpu_assert: protocol checks on the writeback trace ports
`timescale 1ns/1ns
`default_nettype none

module mycpu_assert (
    input logic       aclk,
    input logic       rst_n,
    input logic [3:0] debug_wb_rf_wen,
    input logic [4:0] debug_wb_rf_wnum
);

    wen_whole_word: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wen == 4'h0 || debug_wb_rf_wen == 4'hf)
        else $error("write enable is neither all zeros nor all ones");

    // quiet during reset
    wen_in_reset: assert property (@(posedge aclk) !rst_n |=> debug_wb_rf_wen == 4'h0)
        else $error("write enable set while in reset");

    wen_after_reset: assert property (@(posedge aclk) $rose(rst_n) |=> debug_wb_rf_wen == 4'h0)
        else $error("write enable set on the cycle after reset");

    no_write_r0: assert property (@(posedge aclk) disable iff (!rst_n)
        debug_wb_rf_wen != 4'h0 |-> debug_wb_rf_wnum != 5'd0)
        else $error("write enable paired with register 0");

endmodule

bind mycpu_top mycpu_assert mycpu_assert_inst (
    .aclk             (aclk),
    .rst_n            (rst_n),
    .debug_wb_rf_wen  (debug_wb_rf_wen),
    .debug_wb_rf_wnum (debug_wb_rf_wnum)
);

`default_nettype wire

// ==== test/tb_mycpu.sv ====
// tb_mycpu: random and directed instruction stream into mycpu_top
// trace compared against a reference model two cycles after each strobe
`timescale 1ns/1ns
`default_nettype none

module tb_mycpu import cpu_pkg::*; ();

    typedef struct packed {
        logic        busy;      // slot carried an instruction
        logic [31:0] pc;
        logic        wen;
        logic [4:0]  dst;
        logic [31:0] data;
    } trace_t;

    logic        aclk;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] debug_wb_pc;
    logic [31:0] debug_wb_rf_wdata;
    logic [3:0]  debug_wb_rf_wen;
    logic [4:0]  debug_wb_rf_wnum;

    logic [31:0] lfsr_state;
    logic [31:0] model_pc;
    logic [31:0] model_regs [32];
    trace_t      exp_q [$];
    int          checks;
    int          mismatches;
    int          timeouts;

    clk_gen clk_gen_inst (.clk(aclk));

    mycpu_top mycpu_top_inst (
        .aclk              (aclk),
        .rst_n             (rst_n),
        .instr_valid       (instr_valid),
        .instr             (instr),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    initial begin
        rst_n = 1'b0;
        repeat (8) @(posedge aclk);
        #1 rst_n = 1'b1;
    end

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        b;
        int          i;
        v = '0;
        for (i = 0; i < n; i++) begin
            b = lfsr_state[0];
            lfsr_state = lfsr_state >> 1;
            if (b)
                lfsr_state = lfsr_state ^ 32'h80200003;
            v = {v[30:0], b};
        end
        return v;
    endfunction

    function automatic logic [4:0] pick_reg();
        if (rand_bits(3) == 32'd0)
            return 5'(rand_bits(5));
        return 5'(rand_bits(3));    // mostly low regs, dense dependencies
    endfunction

    function automatic logic [31:0] enc_r(input logic [5:0] fn, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [4:0] rd,
                                          input logic [4:0] sa);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [4:0] rs,
                                          input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic logic [31:0] random_instr();
        logic [3:0]  kind;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  sa;
        logic [15:0] imm;
        logic [5:0]  code;
        kind = 4'(rand_bits(4));
        rs   = pick_reg();
        rt   = pick_reg();
        rd   = pick_reg();
        sa   = 5'(rand_bits(5));
        imm  = 16'(rand_bits(16));
        if (kind < 4'd9) begin
            case (kind)
                4'd0:    code = fn_sll;
                4'd1:    code = fn_srl;
                4'd2:    code = fn_addu;
                4'd3:    code = fn_subu;
                4'd4:    code = fn_and;
                4'd5:    code = fn_or;
                4'd6:    code = fn_xor;
                4'd7:    code = fn_slt;
                default: code = fn_sltu;
            endcase
            if (kind < 4'd2)
                return enc_r(code, 5'd0, rt, rd, sa);
            return enc_r(code, rs, rt, rd, 5'd0);
        end else if (kind < 4'd15) begin
            case (kind)
                4'd9:    code = op_addiu;
                4'd10:   code = op_slti;
                4'd11:   code = op_andi;
                4'd12:   code = op_ori;
                4'd13:   code = op_xori;
                default: code = op_lui;
            endcase
            return enc_i(code, rs, rt, imm);
        end
        if (rand_bits(1) == 32'd1)  // bad major opcode or bad SPECIAL funct
            return enc_i(6'h3f, rs, rt, imm);
        return enc_r(6'h3f, rs, rt, rd, sa);
    endfunction

    // reference model, architectural order
    task automatic predict(input logic [31:0] word, output logic wen,
                           output logic [4:0] dst, output logic [31:0] data);
        logic [5:0]  op;
        logic [5:0]  fn;
        logic [4:0]  sa;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sx;
        logic [31:0] zx;
        logic        ok;
        op   = word[31:26];
        fn   = word[5:0];
        sa   = word[10:6];
        a    = model_regs[word[25:21]];
        b    = model_regs[word[20:16]];
        sx   = {{16{word[15]}}, word[15:0]};
        zx   = {16'h0000, word[15:0]};
        ok   = 1'b1;
        data = 32'd0;
        if (op == op_special) begin
            dst = word[15:11];
            case (fn)
                fn_sll:  data = b << sa;
                fn_srl:  data = b >> sa;
                fn_addu: data = a + b;
                fn_subu: data = a - b;
                fn_and:  data = a & b;
                fn_or:   data = a | b;
                fn_xor:  data = a ^ b;
                fn_slt:  data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                fn_sltu: data = (a < b) ? 32'd1 : 32'd0;
                default: ok = 1'b0;
            endcase
        end else begin
            dst = word[20:16];
            case (op)
                op_addiu: data = a + sx;
                op_slti:  data = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
                op_andi:  data = a & zx;
                op_ori:   data = a | zx;
                op_xori:  data = a ^ zx;
                op_lui:   data = {word[15:0], 16'h0000};
                default:  ok = 1'b0;
            endcase
        end
        wen = ok && (dst != 5'd0);
        if (wen)
            model_regs[dst] = data;
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] got,
                                   input logic [31:0] exp);
        mismatches++;
        $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
    endtask

    task automatic check_trace();
        trace_t e;
        if (exp_q.size() >= 2) begin
            e = exp_q.pop_front();
            checks++;
            if (e.busy) begin
                assert (debug_wb_pc == e.pc)
                    else report_mismatch("debug_wb_pc", debug_wb_pc, e.pc);
                assert (debug_wb_rf_wen == {4{e.wen}})
                    else report_mismatch("debug_wb_rf_wen", 32'(debug_wb_rf_wen),
                                         32'({4{e.wen}}));
                if (e.wen) begin
                    assert (debug_wb_rf_wnum == e.dst)
                        else report_mismatch("debug_wb_rf_wnum", 32'(debug_wb_rf_wnum),
                                             32'(e.dst));
                    assert (debug_wb_rf_wdata == e.data)
                        else report_mismatch("debug_wb_rf_wdata", debug_wb_rf_wdata, e.data);
                end
            end else begin
                assert (debug_wb_rf_wen == 4'h0)
                    else report_mismatch("idle debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'd0);
            end
        end else begin
            // pipeline still filling
            assert (debug_wb_rf_wen == 4'h0)
                else report_mismatch("early debug_wb_rf_wen", 32'(debug_wb_rf_wen), 32'd0);
        end
    endtask

    // one clock: check the slot from two cycles back, then drive
    task automatic step(input logic busy, input logic [31:0] word);
        trace_t      e;
        logic        w;
        logic [4:0]  d;
        logic [31:0] v;
        @(posedge aclk);
        #1;
        check_trace();
        instr_valid = busy;
        instr       = word;
        e           = '0;
        if (busy) begin
            predict(word, w, d, v);
            e.busy   = 1'b1;
            e.pc     = model_pc;
            e.wen    = w;
            e.dst    = d;
            e.data   = v;
            model_pc = model_pc + 32'd4;
        end
        exp_q.push_back(e);
    endtask

    task automatic wait_reset(output logic ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < 20) begin
            @(posedge aclk);
            ok = rst_n;
            n++;
        end
    endtask

    task automatic drain(output logic ok);
        int n;
        int pending;
        n  = 0;
        ok = 1'b0;
        while (!ok && n < 8) begin
            pending = 0;
            foreach (exp_q[i])
                if (exp_q[i].busy)
                    pending++;
            if (pending == 0)
                ok = 1'b1;
            else
                step(1'b0, 32'd0);
            n++;
        end
    endtask

    task automatic run_directed();
        step(1'b1, enc_i(op_addiu, 5'd0, 5'd1, 16'h7fff));
        step(1'b1, enc_r(fn_addu, 5'd1, 5'd1, 5'd2, 5'd0));   // exe bypass
        step(1'b1, enc_r(fn_subu, 5'd2, 5'd1, 5'd3, 5'd0));   // exe and wb bypass
        step(1'b1, enc_i(op_addiu, 5'd0, 5'd5, 16'hffff));
        step(1'b1, enc_r(fn_slt, 5'd5, 5'd1, 5'd4, 5'd0));
        step(1'b1, enc_r(fn_sltu, 5'd5, 5'd1, 5'd6, 5'd0));
        step(1'b1, enc_i(op_slti, 5'd5, 5'd7, 16'h8000));
        step(1'b1, enc_r(fn_sll, 5'd0, 5'd5, 5'd2, 5'd31));
        step(1'b1, enc_r(fn_srl, 5'd0, 5'd2, 5'd3, 5'd4));
        step(1'b1, enc_i(op_lui, 5'd0, 5'd4, 16'h8001));
        step(1'b1, enc_i(op_ori, 5'd4, 5'd4, 16'h1234));
        step(1'b1, enc_i(op_xori, 5'd4, 5'd6, 16'hffff));
        step(1'b1, enc_i(op_andi, 5'd6, 5'd7, 16'h0ff0));
        step(1'b1, enc_r(fn_and, 5'd4, 5'd7, 5'd1, 5'd0));
        step(1'b1, enc_r(fn_or, 5'd1, 5'd6, 5'd2, 5'd0));
        step(1'b1, enc_r(fn_xor, 5'd2, 5'd1, 5'd3, 5'd0));
        step(1'b1, enc_i(op_addiu, 5'd1, 5'd0, 16'h0055));    // $0 write dropped
        step(1'b1, enc_r(fn_addu, 5'd0, 5'd0, 5'd1, 5'd0));   // $0 reads zero
        step(1'b1, enc_i(6'h3f, 5'd1, 5'd2, 16'h1234));
        step(1'b1, enc_r(6'h3f, 5'd1, 5'd2, 5'd3, 5'd0));
        step(1'b0, 32'd0);
    endtask

    initial begin
        logic ok;
        logic busy;
        int   r;
        lfsr_state  = 32'h906e;
        instr_valid = 1'b0;
        instr       = 32'd0;
        checks      = 0;
        mismatches  = 0;
        timeouts    = 0;
        model_pc    = reset_pc;
        for (r = 0; r < 32; r++)
            model_regs[r] = 32'd0;
        wait_reset(ok);
        if (!ok) begin
            timeouts++;
            $display("reset release was not seen within 20 cycles");
        end else begin
            for (r = 1; r < 32; r++)    // regfile has no reset, load every register
                step(1'b1, enc_i(op_addiu, 5'd0, 5'(r), 16'(rand_bits(16))));
            step(1'b0, 32'd0);
            run_directed();
            for (r = 0; r < 400; r++) begin
                busy = (rand_bits(2) != 32'd0);
                step(busy, random_instr());
            end
            drain(ok);
            if (!ok) begin
                timeouts++;
                $display("expected retirements still pending after 8 idle cycles");
            end
        end
        $display("%0d slots checked, %0d mismatches, %0d timeouts", checks, mismatches, timeouts);
        if (mismatches == 0 && timeouts == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
rtl/cpu_pkg.sv
rtl/regfile.sv
rtl/id_stage.sv
rtl/exe_stage.sv
rtl/mycpu_top.sv
test/clk_gen.sv
test/mycpu_assert.sv
test/tb_mycpu.sv
